// File: files.f
logic/cache_geom_pkg.sv
logic/cache_bus_pkg.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_victim_select.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/tb_clock.sv
verif/mem_model.sv
verif/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module cache_tb -Wno-fatal \
        -f files.f --Mdir obj_dir -o sim_cache; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_cache 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: verif/cache_tb.sv
////////////////////////////////////////////////////////////
// cache testbench
// applies a table of CPU accesses to the cache and checks
// read data and refill and write-back counts
////////////////////////////////////////////////////////////
`default_nettype none

module cache_tb;

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        data_t      wdata;
        strb_t      strb;
        logic       check_rd;
        data_t      exp_rd;
        logic       refill;                         // one refill, else no traffic
    } row_t;

    localparam int num_rows = 13;
    localparam int max_wait = 400;

    logic     clk;
    logic     rst;
    logic     cpu_req_valid;
    cpu_req_t cpu_req;
    logic     cpu_req_ready;
    data_t    cpu_rsp_data;
    logic     mem_w_valid;
    mem_wr_t  mem_w;
    logic     mem_w_ready;
    addr_t    mem_r_addr;
    logic     mem_r_ready;
    logic     mem_r_valid;
    data_t    mem_r_data;
    int       refill_count;
    int       wb_count;
    logic     mem_error;

    row_t     access_rows [num_rows];
    int       row_cnt;

    tb_clock u_clock (.clk(clk));

    mem_model u_mem (.*, .error(mem_error));

    cache_top #(.lfsr_seed(8'h01)) dut (.*);

    task automatic finish_failed(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        finish_failed($sformatf("** Error at time %0t: %s", $time, msg));
    endtask

    function automatic data_t pattern(input addr_t a);
        return {a & ~addr_t'(7), ~(a & ~addr_t'(7))};   // word aligned address
    endfunction

    function automatic data_t merge(input data_t old, input data_t wd, input strb_t st);
        data_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (st[b]) begin
                res[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_row(input logic wr, input addr_t a, input data_t wd, input strb_t st,
                           input logic chk, input data_t exp, input logic refill);
        access_rows[row_cnt] = '{write: wr, addr: a, wdata: wd, strb: st, check_rd: chk,
                                 exp_rd: exp, refill: refill};
        row_cnt = row_cnt + 1;
    endtask

    task automatic build_rows();
        addr_t a;
        addr_t b;
        addr_t c;
        data_t wa;
        data_t wb;
        a  = 32'h0000_1048;                         // index 1, word 1
        b  = 32'h0000_2058;                         // index 1, other tag
        wa = 64'h1111_2222_3333_4444;
        wb = 64'haaaa_bbbb_cccc_dddd;
        row_cnt = 0;
        add_row(1'b0, a, '0, '0, 1'b1, pattern(a), 1'b1);
        add_row(1'b0, a + 32'h28, '0, '0, 1'b1, pattern(a + 32'h28), 1'b0);
        add_row(1'b1, a, wa, 8'h0f, 1'b0, '0, 1'b0);
        add_row(1'b0, a, '0, '0, 1'b1, merge(pattern(a), wa, 8'h0f), 1'b0);
        add_row(1'b1, b, wb, 8'hf0, 1'b0, '0, 1'b1);
        add_row(1'b0, b, '0, '0, 1'b1, merge(pattern(b), wb, 8'hf0), 1'b0);
        for (int i = 0; i < 5; i++) begin
            c = {22'(32'h10 + i), 4'd1, 3'd2, 3'd0};
            add_row(1'b0, c, '0, '0, 1'b1, pattern(c), 1'b1);
        end
        // seed 01 victims are ways 1, 2, 0 so both lines come back from memory
        add_row(1'b0, a, '0, '0, 1'b1, merge(pattern(a), wa, 8'h0f), 1'b1);
        add_row(1'b0, b, '0, '0, 1'b1, merge(pattern(b), wb, 8'hf0), 1'b1);
    endtask

    task automatic apply_row(input row_t r, input int idx);
        int    refills_before;
        int    wbs_before;
        logic  seen;
        data_t rsp;
        refills_before = refill_count;
        wbs_before     = wb_count;
        @(negedge clk);
        cpu_req_valid = 1'b1;
        cpu_req       = '{addr: r.addr, write: r.write, wdata: r.wdata, wstrb: r.strb};
        seen = 1'b0;
        for (int n = 0; n < max_wait && !seen; n++) begin
            #10;                                    // mid low phase, all settled
            if (cpu_req_ready) begin
                seen = 1'b1;
                rsp  = cpu_rsp_data;
            end else begin
                @(negedge clk);
            end
        end
        assert (seen) else finish_failed($sformatf("row %0d got no cpu_req_ready", idx));
        @(negedge clk);
        cpu_req_valid = 1'b0;
        seen = 1'b0;
        for (int n = 0; n < max_wait && !seen; n++) begin
            #10;
            if (!mem_r_ready && !mem_w_valid) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        assert (seen) else finish_failed($sformatf("row %0d memory bursts never ended", idx));
        if (r.check_rd) begin
            assert (rsp == r.exp_rd) else
                value_error($sformatf("row %0d read %h, expected %h", idx, rsp, r.exp_rd));
        end
        if (!r.refill) begin
            assert (refill_count == refills_before && wb_count == wbs_before) else
                value_error($sformatf("row %0d caused memory traffic", idx));
        end else begin
            assert (refill_count == refills_before + 1) else
                value_error($sformatf("row %0d refills %0d, expected 1", idx,
                                      refill_count - refills_before));
        end
    endtask

    always @(negedge clk) begin
        assert (!mem_error) else finish_failed("memory model saw a bad burst");
    end

    initial begin
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        build_rows();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i == 7) begin
                rst = 1'b0;
            end
            #10;
            assert (!cpu_req_ready && !mem_w_valid && !mem_r_ready) else
                finish_failed("handshake outputs active during reset");
        end
        repeat (2) begin
            @(negedge clk);
            #10;
            assert (!cpu_req_ready && !mem_w_valid && !mem_r_ready) else
                finish_failed("handshake outputs active after reset");
        end
        for (int i = 0; i < row_cnt; i++) begin
            apply_row(access_rows[i], i);
        end
        assert (wb_count >= 1) else finish_failed("no write-back burst seen");
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/mem_model.sv
////////////////////////////////////////////////////////////
// memory model
// answers wrap refill bursts, takes write-back bursts,
// inserts random stalls and checks burst order
////////////////////////////////////////////////////////////
`default_nettype none

module mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_w_valid,
    input  cache_bus_pkg::mem_wr_t mem_w,
    output logic                   mem_w_ready,
    input  cache_geom_pkg::addr_t  mem_r_addr,
    input  logic                   mem_r_ready,
    output logic                   mem_r_valid,
    output cache_geom_pkg::data_t  mem_r_data,
    output int                     refill_count,
    output int                     wb_count,
    output logic                   error
);

    import cache_geom_pkg::*;

    logic [31:0] lfsr;
    data_t       backing [addr_t];                  // only written words
    int          r_beat;
    int          w_beat;
    addr_t       r_addr_q;
    addr_t       w_first;
    addr_t       w_expect;
    logic        stall;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // two bits per draw, stall one time in four
    task automatic draw_stall(output logic stall_o);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
        stall_o = (bits == 2'b00);
    endtask

    function automatic data_t read_word(input addr_t a);
        if (backing.exists(a)) begin
            return backing[a];
        end
        return {a, ~a};                             // address high, inverse low
    endfunction

    function automatic addr_t wrap_addr(input addr_t first, input int beat);
        return {first[31:6], word_sel_t'(int'(first[5:3]) + beat), 3'b000};
    endfunction

    initial begin
        lfsr        = 32'hc59000f4;
        mem_w_ready = 1'b0;
        mem_r_valid = 1'b0;
        mem_r_data  = '0;
    end

    // drive side, on the falling edge
    always @(negedge clk) begin
        draw_stall(stall);
        mem_w_ready = !stall;
        if (mem_r_ready) begin
            draw_stall(stall);
            mem_r_valid = !stall;
            mem_r_data  = read_word(wrap_addr(mem_r_addr, r_beat));
        end else begin
            mem_r_valid = 1'b0;
        end
    end

    // transfer side, on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            r_beat       = 0;
            w_beat       = 0;
            refill_count = 0;
            wb_count     = 0;
            error        = 1'b0;
        end else begin
            assert (mem_r_ready || r_beat == 0) else begin
                $display("refill burst stopped after %0d beats", r_beat);
                error = 1'b1;
            end
            assert (mem_w_valid || w_beat == 0) else begin
                $display("write-back burst stopped after %0d beats", w_beat);
                error = 1'b1;
            end
            if (mem_r_valid && mem_r_ready) begin
                if (r_beat == 0) begin
                    r_addr_q = mem_r_addr;
                end
                assert (mem_r_addr == r_addr_q && mem_r_addr[2:0] == 3'b000) else begin
                    $display("** Error at time %0t: refill address %h, expected %h",
                             $time, mem_r_addr, r_addr_q);
                    error = 1'b1;
                end
                r_beat = r_beat + 1;
                if (r_beat == beats_per_line) begin
                    r_beat       = 0;
                    refill_count = refill_count + 1;
                end
            end
            if (mem_w_valid && mem_w_ready) begin
                if (w_beat == 0) begin
                    w_first = mem_w.addr;
                end
                w_expect = wrap_addr(w_first, w_beat);
                assert (mem_w.addr == w_expect) else begin
                    $display("** Error at time %0t: write-back beat %0d address %h, expected %h",
                             $time, w_beat, mem_w.addr, w_expect);
                    error = 1'b1;
                end
                backing[mem_w.addr] = mem_w.data;
                w_beat = w_beat + 1;
                if (w_beat == beats_per_line) begin
                    w_beat   = 0;
                    wb_count = wb_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
////////////////////////////////////////////////////////////
// testbench clock
// free running clock, 40 time units per period
////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock #(
    parameter int half_period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: logic/cache_top.sv
////////////////////////////////////////////////////////////
// cache top
// 4 KB 4-way write-back data cache: controller, tag and
// data stores and the random victim selector
////////////////////////////////////////////////////////////
`default_nettype none

module cache_top #(
    parameter logic [7:0] lfsr_seed = 8'h01
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cpu_req_valid,
    input  cache_bus_pkg::cpu_req_t cpu_req,
    output logic                    cpu_req_ready,
    output cache_geom_pkg::data_t   cpu_rsp_data,
    output logic                    mem_w_valid,
    output cache_bus_pkg::mem_wr_t  mem_w,
    input  logic                    mem_w_ready,
    output cache_geom_pkg::addr_t   mem_r_addr,
    output logic                    mem_r_ready,
    input  logic                    mem_r_valid,
    input  cache_geom_pkg::data_t   mem_r_data
);

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    addr_t      lookup_addr;
    logic       hit;
    way_t       hit_way;
    logic       full;
    way_t       empty_way;
    tag_entry_t evict_entry;
    logic       tag_we;
    way_t       tag_way;
    index_t     tag_index;
    tag_entry_t tag_wdata;
    data_port_t data_port;
    data_t      data_rdata;
    logic       replace_step;
    way_t       victim_way;

    cache_ctrl u_ctrl (.*);

    cache_tag_store u_tag_store (.*);

    cache_data_store u_data_store (
        .clk       (clk),
        .data_port (data_port),
        .rdata     (data_rdata)
    );

    cache_victim_select #(
        .lfsr_seed (lfsr_seed)
    ) u_victim_select (
        .clk          (clk),
        .rst          (rst),
        .replace_step (replace_step),
        .victim_way   (victim_way)
    );

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
////////////////////////////////////////////////////////////
// cache controller
// FSM for hits, dirty write-backs and wrap-burst refills,
// driving the tag store and the data store
////////////////////////////////////////////////////////////
`default_nettype none

module cache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_req_valid,
    input  cache_bus_pkg::cpu_req_t    cpu_req,
    output logic                       cpu_req_ready,
    output cache_geom_pkg::data_t      cpu_rsp_data,
    output logic                       mem_w_valid,
    output cache_bus_pkg::mem_wr_t     mem_w,
    input  logic                       mem_w_ready,
    output cache_geom_pkg::addr_t      mem_r_addr,
    output logic                       mem_r_ready,
    input  logic                       mem_r_valid,
    input  cache_geom_pkg::data_t      mem_r_data,
    output cache_geom_pkg::addr_t      lookup_addr,
    input  logic                       hit,
    input  cache_geom_pkg::way_t       hit_way,
    input  logic                       full,
    input  cache_geom_pkg::way_t       empty_way,
    input  cache_bus_pkg::tag_entry_t  evict_entry,
    output logic                       tag_we,
    output cache_geom_pkg::way_t       tag_way,
    output cache_geom_pkg::index_t     tag_index,
    output cache_bus_pkg::tag_entry_t  tag_wdata,
    output cache_bus_pkg::data_port_t  data_port,
    input  cache_geom_pkg::data_t      data_rdata,
    output logic                       replace_step,
    input  cache_geom_pkg::way_t       victim_way
);

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    ctrl_state_t state;
    word_sel_t   beat_cnt;
    word_sel_t   word_ptr;                          // wraps inside the line
    logic        repl_q;                            // miss went into a full set

    cpu_req_t    req_q;
    way_t        fill_way_q;
    tag_t        evict_tag_q;

    logic        first_beat;
    logic        last_beat;
    logic        need_wb;
    data_t       fill_word;

    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == word_sel_t'(beats_per_line - 1));
    assign need_wb    = full && evict_entry.dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            beat_cnt <= '0;
            word_ptr <= '0;
            repl_q   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (cpu_req_valid) begin
                        word_ptr <= addr_word(cpu_req.addr);   // critical word first
                        beat_cnt <= '0;
                        repl_q   <= full;
                        if (hit) begin
                            state <= st_hit;
                        end else if (need_wb) begin
                            state <= st_wb_prep;
                        end else begin
                            state <= st_refill;
                        end
                    end
                end
                st_hit:     state <= st_idle;
                st_wb_prep: state <= st_writeback;
                st_writeback: begin
                    if (mem_w_ready) begin
                        word_ptr <= word_ptr + word_sel_t'(1);
                        beat_cnt <= beat_cnt + word_sel_t'(1);
                        if (last_beat) begin
                            state <= st_refill;         // ptr is back at start
                        end
                    end
                end
                st_refill: begin
                    if (mem_r_valid) begin
                        word_ptr <= word_ptr + word_sel_t'(1);
                        beat_cnt <= beat_cnt + word_sel_t'(1);
                        if (last_beat) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cpu_req_valid) begin
            req_q       <= cpu_req;
            fill_way_q  <= full ? victim_way : empty_way;
            evict_tag_q <= evict_entry.tag;
        end
    end

    // CPU store merged into the critical refill beat
    always_comb begin
        fill_word = mem_r_data;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (first_beat && req_q.write && req_q.wstrb[b]) begin
                fill_word[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        data_port       = '0;
        data_port.way   = fill_way_q;
        data_port.index = addr_index(req_q.addr);
        data_port.word  = word_ptr;
        tag_we          = 1'b0;
        tag_way         = fill_way_q;
        tag_index       = addr_index(req_q.addr);
        tag_wdata       = '{valid: 1'b1, dirty: req_q.write, tag: addr_tag(req_q.addr)};
        replace_step    = 1'b0;
        case (state)
            st_idle: begin
                data_port.way   = hit_way;
                data_port.index = addr_index(cpu_req.addr);
                data_port.word  = addr_word(cpu_req.addr);
                data_port.we    = cpu_req_valid && hit && cpu_req.write;
                data_port.wdata = cpu_req.wdata;
                data_port.wstrb = cpu_req.wstrb;
                tag_we          = cpu_req_valid && hit && cpu_req.write;   // mark dirty
                tag_way         = hit_way;
                tag_index       = addr_index(cpu_req.addr);
                tag_wdata       = '{valid: 1'b1, dirty: 1'b1, tag: addr_tag(cpu_req.addr)};
            end
            st_writeback: begin
                if (mem_w_ready) begin
                    data_port.word = word_ptr + word_sel_t'(1);  // read ahead
                end
            end
            st_refill: begin
                data_port.we    = mem_r_valid;
                data_port.wdata = fill_word;
                data_port.wstrb = '1;
                if (mem_r_valid && last_beat) begin
                    tag_we       = 1'b1;
                    replace_step = repl_q;
                end
            end
            default: begin
                data_port.we = 1'b0;                // hit and wb_prep only read
            end
        endcase
    end

    assign lookup_addr   = (state == st_idle) ? cpu_req.addr : req_q.addr;
    assign cpu_req_ready = (state == st_hit) ||
                           (state == st_refill && first_beat && mem_r_valid);
    assign cpu_rsp_data  = (state == st_hit) ? data_rdata : fill_word;

    assign mem_w_valid   = (state == st_writeback);
    assign mem_w         = '{addr: word_addr(evict_tag_q, addr_index(req_q.addr), word_ptr),
                             data: data_rdata};

    assign mem_r_ready   = (state == st_refill);
    assign mem_r_addr    = word_addr(addr_tag(req_q.addr), addr_index(req_q.addr),
                                     addr_word(req_q.addr));

endmodule

`default_nettype wire

// File: logic/cache_victim_select.sv
////////////////////////////////////////////////////////////
// cache victim select
// 8-bit LFSR giving a random way for refills into a full set
////////////////////////////////////////////////////////////
`default_nettype none

module cache_victim_select #(
    parameter logic [7:0] lfsr_seed = 8'h01
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 replace_step,
    output cache_geom_pkg::way_t victim_way
);

    import cache_geom_pkg::*;

    logic [7:0] lfsr;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= lfsr_seed;
        end else if (replace_step) begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    assign victim_way = lfsr[$bits(way_t)-1:0];     // low bits pick the way

endmodule

`default_nettype wire

// File: logic/cache_data_store.sv
////////////////////////////////////////////////////////////
// cache data store
// line data of all ways, byte-strobed writes and a
// registered one-cycle read
////////////////////////////////////////////////////////////
`default_nettype none

module cache_data_store (
    input  logic                      clk,
    input  cache_bus_pkg::data_port_t data_port,
    output cache_geom_pkg::data_t     rdata
);

    import cache_geom_pkg::*;

    localparam int depth = num_ways * num_sets * beats_per_line;

    data_t                    ram [depth];
    logic [$clog2(depth)-1:0] ram_addr;

    assign ram_addr = {data_port.way, data_port.index, data_port.word};

    always_ff @(posedge clk) begin
        if (data_port.we) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (data_port.wstrb[b]) begin
                    ram[ram_addr][b*8 +: 8] <= data_port.wdata[b*8 +: 8];
                end
            end
        end
        rdata <= ram[ram_addr];                     // old data on a same-cycle write
    end

endmodule

`default_nettype wire

// File: logic/cache_tag_store.sv
////////////////////////////////////////////////////////////
// cache tag store
// tag, valid and dirty bits for all sets and ways, with a
// parallel lookup of the addressed set
////////////////////////////////////////////////////////////
`default_nettype none

module cache_tag_store (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_geom_pkg::addr_t      lookup_addr,
    input  logic                       tag_we,
    input  cache_geom_pkg::way_t       tag_way,
    input  cache_geom_pkg::index_t     tag_index,
    input  cache_bus_pkg::tag_entry_t  tag_wdata,
    input  cache_geom_pkg::way_t       victim_way,
    output logic                       hit,
    output cache_geom_pkg::way_t       hit_way,
    output logic                       full,
    output cache_geom_pkg::way_t       empty_way,
    output cache_bus_pkg::tag_entry_t  evict_entry
);

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    tag_t                tag_mem    [num_sets][num_ways];
    logic [num_ways-1:0] valid_bits [num_sets];
    logic [num_ways-1:0] dirty_bits [num_sets];

    tag_t   lk_tag;
    index_t lk_index;

    assign lk_tag   = addr_tag(lookup_addr);
    assign lk_index = addr_index(lookup_addr);

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[tag_index][tag_way] <= tag_wdata.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
            end
        end else if (tag_we) begin
            valid_bits[tag_index][tag_way] <= tag_wdata.valid;
            dirty_bits[tag_index][tag_way] <= tag_wdata.dirty;
        end
    end

    // walk down so the lowest way wins
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        full      = 1'b1;
        empty_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (valid_bits[lk_index][w] && tag_mem[lk_index][w] == lk_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (!valid_bits[lk_index][w]) begin
                full      = 1'b0;
                empty_way = way_t'(w);
            end
        end
    end

    assign evict_entry = '{valid: valid_bits[lk_index][victim_way],
                           dirty: dirty_bits[lk_index][victim_way],
                           tag:   tag_mem[lk_index][victim_way]};

endmodule

`default_nettype wire

// File: logic/cache_bus_pkg.sv
////////////////////////////////////////////////////////////
// cache bus types
// request, tag entry, data store access and write beat
// structs, plus the controller state encoding
////////////////////////////////////////////////////////////
`default_nettype none

package cache_bus_pkg;

    import cache_geom_pkg::*;

    typedef struct packed {
        addr_t addr;
        logic  write;                // 1 = store, 0 = load
        data_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        way_t      way;
        index_t    index;
        word_sel_t word;
        logic      we;
        data_t     wdata;
        strb_t     wstrb;            // byte enables when we is set
    } data_port_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_hit,
        st_wb_prep,                  // data store read-ahead before write-back
        st_writeback,
        st_refill
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/cache_geom_pkg.sv
////////////////////////////////////////////////////////////
// cache geometry
// sizes of the 4 KB 4-way data cache, address field
// typedefs and helpers that split and build addresses
////////////////////////////////////////////////////////////
`default_nettype none

package cache_geom_pkg;

    localparam int addr_width     = 32;
    localparam int data_width     = 64;
    localparam int num_ways       = 4;
    localparam int num_sets       = 16;
    localparam int beats_per_line = 8;               // words per line, burst length

    localparam int byte_bits  = $clog2(data_width / 8);  // byte-in-word, ignored
    localparam int word_bits  = $clog2(beats_per_line);
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits   = addr_width - index_bits - word_bits - byte_bits;

    typedef logic [addr_width-1:0]       addr_t;
    typedef logic [tag_bits-1:0]         tag_t;      // addr 31..10
    typedef logic [index_bits-1:0]       index_t;    // addr 9..6
    typedef logic [word_bits-1:0]        word_sel_t; // addr 5..3
    typedef logic [$clog2(num_ways)-1:0] way_t;
    typedef logic [data_width-1:0]       data_t;
    typedef logic [data_width/8-1:0]     strb_t;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[addr_width-1 -: tag_bits];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[byte_bits + word_bits +: index_bits];
    endfunction

    function automatic word_sel_t addr_word(input addr_t addr);
        return addr[byte_bits +: word_bits];
    endfunction

    // word aligned byte address of one word in a line
    function automatic addr_t word_addr(input tag_t tag, input index_t index,
                                        input word_sel_t word);
        return {tag, index, word, {byte_bits{1'b0}}};
    endfunction

endpackage

`default_nettype wire
